/* Makefile */
# Verilator build and run of the board glue testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_board_glue \
		-f verilog.f -o tb_board_glue
	./obj_dir/tb_board_glue | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* design/audio_mix.sv */
// Audio sample path
// Channel exchange and centred mix in one registered stage
module audio_mix (
  input  logic               clk,
  input  logic               i_reset,
  board_cfg_if.audio         cfg,
  input  logic               i_sample_valid,
  input  board_pkg::sample_t i_left,
  input  board_pkg::sample_t i_right,
  output logic               o_sample_valid,
  output board_pkg::sample_t o_left,
  output board_pkg::sample_t o_right
);

  board_pkg::sample_t                 a;          // Left after exchange
  board_pkg::sample_t                 b;          // Right after exchange
  logic signed [board_pkg::MIX_W-1:0] wide_a;
  logic signed [board_pkg::MIX_W-1:0] wide_b;
  logic signed [board_pkg::MIX_W-1:0] sum_l;      // 3a + b
  logic signed [board_pkg::MIX_W-1:0] sum_r;      // 3b + a
  logic signed [board_pkg::MIX_W-1:0] shr_l;
  logic signed [board_pkg::MIX_W-1:0] shr_r;
  board_pkg::sample_t                 left_d;
  board_pkg::sample_t                 right_d;
  logic                               valid_q;
  board_pkg::sample_t                 left_q;
  board_pkg::sample_t                 right_q;

  always_comb begin
    a      = cfg.exchan ? i_right : i_left;      // Swap first
    b      = cfg.exchan ? i_left  : i_right;
    wide_a = a;                                  // Sign-extended
    wide_b = b;
    sum_l  = (wide_a <<< 1) + wide_a + wide_b;
    sum_r  = (wide_b <<< 1) + wide_b + wide_a;
    shr_l  = sum_l >>> 2;                        // Back to unity gain
    shr_r  = sum_r >>> 2;
    left_d  = cfg.mix ? shr_l[board_pkg::SAMPLE_W-1:0] : a;
    right_d = cfg.mix ? shr_r[board_pkg::SAMPLE_W-1:0] : b;
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_sample_valid;                 // No back-pressure
    end
  end

  always_ff @(posedge clk) begin
    if (i_sample_valid) begin
      left_q  <= left_d;
      right_q <= right_d;
    end
  end

  assign o_sample_valid = valid_q;
  assign o_left         = left_q;
  assign o_right        = right_q;

  // Fixed one-cycle latency
  a_latency : assert property (@(posedge clk) disable iff (i_reset)
    !$past(i_reset) |-> o_sample_valid == $past(i_sample_valid));

endmodule

/* design/board_cfg_if.sv */
// Configuration interface: CTRL fields out of the register block,
// system status into it and into the indicators
interface board_cfg_if;

  logic                           uart_ctrl;   // UART owned by control processor
  logic                           exchan;      // Swap audio channels
  logic                           mix;         // Centred audio mix
  logic                           scan15k;     // Scandoubler disable
  logic                           cache_en;    // CPU cache enable
  logic [board_pkg::STATUS_W-1:0] sys_status;  // Driven at the top

  // Register block owns the fields
  modport csr (
    output uart_ctrl, exchan, mix, scan15k, cache_en,
    input  sys_status
  );

  // Sample path needs only the audio options
  modport audio (
    input exchan, mix
  );

  // Indicators show everything
  modport disp (
    input uart_ctrl, exchan, mix, scan15k, cache_en, sys_status
  );

endinterface

/* design/board_csr.sv */
// AXI4-Lite register block
// CTRL register, STATUS and ID readback, write and read responses
module board_csr (
  input  logic                         i_clk,
  input  logic                         i_reset,
  // Write address
  input  logic [csr_pkg::ADDR_W-1:0]   i_awaddr,
  input  logic                         i_awvalid,
  output logic                         o_awready,
  // Write data
  input  logic [csr_pkg::DATA_W-1:0]   i_wdata,
  input  logic [csr_pkg::DATA_W/8-1:0] i_wstrb,
  input  logic                         i_wvalid,
  output logic                         o_wready,
  // Write response
  output logic [1:0]                   o_bresp,
  output logic                         o_bvalid,
  input  logic                         i_bready,
  // Read address
  input  logic [csr_pkg::ADDR_W-1:0]   i_araddr,
  input  logic                         i_arvalid,
  output logic                         o_arready,
  // Read data
  output logic [csr_pkg::DATA_W-1:0]   o_rdata,
  output logic [1:0]                   o_rresp,
  output logic                         o_rvalid,
  input  logic                         i_rready,
  // Configuration
  board_cfg_if.csr                     cfg
);

  logic [csr_pkg::CTRL_W-1:0] ctrl_q;     // Control register
  logic                       awready_q;  // One-cycle accept pulse, AW and W
  logic                       bvalid_q;
  csr_pkg::resp_e             bresp_q;
  logic                       rvalid_q;
  csr_pkg::resp_e             rresp_q;
  logic [csr_pkg::DATA_W-1:0] rdata_q;
  logic                       wr_hs;      // Write handshake this cycle
  logic                       rd_hs;      // Read handshake this cycle
  logic                       ctrl_we;
  csr_pkg::resp_e             wr_resp;
  logic [csr_pkg::DATA_W-1:0] rd_data;
  csr_pkg::resp_e             rd_resp;

  //////////////////////////////
  // Write channel
  //////////////////////////////

  assign wr_hs = awready_q & i_awvalid & i_wvalid;

  always_comb begin
    ctrl_we = 1'b0;
    wr_resp = csr_pkg::RESP_SLVERR;                 // RO and holes
    case (csr_pkg::reg_addr_e'(i_awaddr))
      csr_pkg::REG_CTRL: begin
        ctrl_we = i_wstrb[0];                       // Lane 0 holds all fields
        wr_resp = csr_pkg::RESP_OKAY;
      end
      default: begin
        ctrl_we = 1'b0;
      end
    endcase
  end

  //////////////////////////////
  // Read channel
  //////////////////////////////

  assign rd_hs = i_arvalid & ~rvalid_q;

  always_comb begin
    rd_data = '0;
    rd_resp = csr_pkg::RESP_OKAY;
    case (csr_pkg::reg_addr_e'(i_araddr))
      csr_pkg::REG_CTRL:   rd_data[csr_pkg::CTRL_W-1:0] = ctrl_q;
      csr_pkg::REG_STATUS: rd_data[board_pkg::STATUS_W-1:0] = cfg.sys_status;  // Live
      csr_pkg::REG_ID:     rd_data = csr_pkg::BOARD_ID;
      default:             rd_resp = csr_pkg::RESP_SLVERR;
    endcase
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ctrl_q    <= '0;
      awready_q <= 1'b0;
      bvalid_q  <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      awready_q <= ~awready_q & i_awvalid & i_wvalid & ~bvalid_q;  // Stall on pending B
      if (wr_hs && ctrl_we) begin
        ctrl_q <= i_wdata[csr_pkg::CTRL_W-1:0];
      end
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (i_bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (i_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Response payload
  always_ff @(posedge i_clk) begin
    if (wr_hs) begin
      bresp_q <= wr_resp;
    end
    if (rd_hs) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  assign o_awready = awready_q;
  assign o_wready  = awready_q;                     // AW and W accepted together
  assign o_bvalid  = bvalid_q;
  assign o_bresp   = bresp_q;
  assign o_arready = ~rvalid_q;                     // Stall on pending R
  assign o_rvalid  = rvalid_q;
  assign o_rdata   = rdata_q;
  assign o_rresp   = rresp_q;

  // Field fan-out
  assign cfg.uart_ctrl = ctrl_q[csr_pkg::CTRL_UART_CTRL];
  assign cfg.exchan    = ctrl_q[csr_pkg::CTRL_EXCHAN];
  assign cfg.mix       = ctrl_q[csr_pkg::CTRL_MIX];
  assign cfg.scan15k   = ctrl_q[csr_pkg::CTRL_SCAN15K];
  assign cfg.cache_en  = ctrl_q[csr_pkg::CTRL_CACHE_EN];

  // Responses hold until taken
  a_bvalid_hold : assert property (@(posedge i_clk) disable iff (i_reset)
    bvalid_q && !i_bready |=> bvalid_q && $stable(bresp_q));
  a_rvalid_hold : assert property (@(posedge i_clk) disable iff (i_reset)
    rvalid_q && !i_rready |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q));

endmodule

/* design/board_glue_top.sv */
// Board glue top level
// AXI4-Lite register port, UART routing, audio and indicator instances
module board_glue_top (
  input  logic                         clk,
  input  logic                         i_reset,
  // AXI4-Lite
  input  logic [csr_pkg::ADDR_W-1:0]   i_awaddr,
  input  logic                         i_awvalid,
  output logic                         o_awready,
  input  logic [csr_pkg::DATA_W-1:0]   i_wdata,
  input  logic [csr_pkg::DATA_W/8-1:0] i_wstrb,
  input  logic                         i_wvalid,
  output logic                         o_wready,
  output logic [1:0]                   o_bresp,
  output logic                         o_bvalid,
  input  logic                         i_bready,
  input  logic [csr_pkg::ADDR_W-1:0]   i_araddr,
  input  logic                         i_arvalid,
  output logic                         o_arready,
  output logic [csr_pkg::DATA_W-1:0]   o_rdata,
  output logic [1:0]                   o_rresp,
  output logic                         o_rvalid,
  input  logic                         i_rready,
  // Status sources
  input  logic [board_pkg::STATUS_W-1:0] i_sys_status,
  input  logic [board_pkg::TRACK_W-1:0]  i_track,
  input  logic [board_pkg::ACT_N-1:0]    i_act,
  // Audio
  input  logic                         i_sample_valid,
  input  board_pkg::sample_t           i_left,
  input  board_pkg::sample_t           i_right,
  output logic                         o_sample_valid,
  output board_pkg::sample_t           o_left,
  output board_pkg::sample_t           o_right,
  // UART
  input  logic                         i_ctrl_txd,   // Control processor TX
  output logic                         o_ctrl_rxd,
  input  logic                         i_core_txd,   // Core TX
  output logic                         o_core_rxd,
  input  logic                         i_uart_rxd,   // Board pin
  output logic                         o_uart_txd,
  // Core options
  output logic                         o_scan15k,
  output logic                         o_cache_en,
  // Indicators
  output logic [board_pkg::SEG_W-1:0]  o_hex0,
  output logic [board_pkg::SEG_W-1:0]  o_hex1,
  output logic [board_pkg::SEG_W-1:0]  o_hex2,
  output logic [board_pkg::SEG_W-1:0]  o_hex3,
  output logic [board_pkg::LEDG_W-1:0] o_ledg,
  output logic [board_pkg::LEDR_W-1:0] o_ledr
);

  board_cfg_if cfg ();

  assign cfg.sys_status = i_sys_status;

  //////////////////////////////
  // UART routing
  //////////////////////////////

  assign o_uart_txd = cfg.uart_ctrl ? i_ctrl_txd : i_core_txd;
  assign o_ctrl_rxd = cfg.uart_ctrl ? i_uart_rxd : 1'b1;   // Idle high when not owner
  assign o_core_rxd = cfg.uart_ctrl ? 1'b1       : i_uart_rxd;

  assign o_scan15k  = cfg.scan15k;
  assign o_cache_en = cfg.cache_en;

  //////////////////////////////
  // Instances
  //////////////////////////////

  board_csr u_csr (
    .i_clk     (clk),
    .i_reset   (i_reset),
    .i_awaddr  (i_awaddr),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .o_bresp   (o_bresp),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .i_araddr  (i_araddr),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .cfg       (cfg.csr)
  );

  audio_mix u_audio (
    .clk            (clk),
    .i_reset        (i_reset),
    .cfg            (cfg.audio),
    .i_sample_valid (i_sample_valid),
    .i_left         (i_left),
    .i_right        (i_right),
    .o_sample_valid (o_sample_valid),
    .o_left         (o_left),
    .o_right        (o_right)
  );

  status_display #(
    .STRETCH (board_pkg::STRETCH_LEN)
  ) u_disp (
    .clk     (clk),
    .i_reset (i_reset),
    .cfg     (cfg.disp),
    .i_track (i_track),
    .i_act   (i_act),
    .o_hex0  (o_hex0),
    .o_hex1  (o_hex1),
    .o_hex2  (o_hex2),
    .o_hex3  (o_hex3),
    .o_ledg  (o_ledg),
    .o_ledr  (o_ledr)
  );

endmodule

/* design/board_pkg.sv */
// Board package: datapath widths, seven-segment constants,
// activity strobe naming and LED stretch length
package board_pkg;

  // Datapath widths
  localparam int SAMPLE_W    = 15;              // Audio sample
  localparam int MIX_W       = SAMPLE_W + 2;    // 3*a + b headroom
  localparam int TRACK_W     = 8;               // Floppy track number
  localparam int STATUS_W    = 4;               // System status
  localparam int SEG_W       = 7;               // One digit, gfedcba
  localparam int LEDG_W      = 8;               // Green LEDs
  localparam int LEDR_W      = 10;              // Red LEDs
  localparam int ACT_N       = 4;               // Activity strobes
  localparam int STRETCH_LEN = 8;               // Cycles an activity LED stays lit

  // Active-low digit patterns
  localparam logic [SEG_W-1:0] SEG_BLANK = 7'h7f;   // All segments off
  localparam logic [SEG_W-1:0] SEG_HEX [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30,                     // 0 1 2 3
    7'h19, 7'h12, 7'h02, 7'h78,                     // 4 5 6 7
    7'h00, 7'h10, 7'h08, 7'h03,                     // 8 9 A b
    7'h46, 7'h21, 7'h06, 7'h0e                      // C d E F
  };

  // One signed audio sample
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Activity strobes, value is the green LED index
  typedef enum logic [1:0] {
    ACT_FLOPPY_WR = 2'd0,                           // Floppy FIFO write
    ACT_FLOPPY_RD = 2'd1,                           // Floppy FIFO read
    ACT_HD_WR     = 2'd2,                           // HD FIFO write
    ACT_HD_RD     = 2'd3                            // HD FIFO read
  } act_e;

endpackage

/* design/csr_pkg.sv */
// Register map package: bus widths, register addresses,
// CTRL field positions, response codes, identity word
package csr_pkg;

  // AXI4-Lite widths
  localparam int ADDR_W = 4;
  localparam int DATA_W = 32;

  // Register addresses
  typedef enum logic [ADDR_W-1:0] {
    REG_CTRL   = 4'h0,                    // Control, RW
    REG_STATUS = 4'h4,                    // System status, RO
    REG_ID     = 4'h8                     // Identity, RO
  } reg_addr_e;

  // CTRL field positions
  localparam int CTRL_UART_CTRL = 0;      // UART to control processor
  localparam int CTRL_EXCHAN    = 1;      // Swap left / right
  localparam int CTRL_MIX       = 2;      // Centred mix
  localparam int CTRL_SCAN15K   = 3;      // Scandoubler disable
  localparam int CTRL_CACHE_EN  = 4;      // CPU cache enable
  localparam int CTRL_W         = 5;

  // Response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Identity word, "MMG1"
  localparam logic [DATA_W-1:0] BOARD_ID = 32'h4d4d_4731;

endpackage

/* design/status_display.sv */
// Status indicators
// Seven-segment track and status digits, stretched activity LEDs,
// configuration mirror on the red LEDs
module status_display #(
  parameter int STRETCH = board_pkg::STRETCH_LEN
) (
  input  logic                            clk,
  input  logic                            i_reset,
  board_cfg_if.disp                       cfg,
  input  logic [board_pkg::TRACK_W-1:0]   i_track,
  input  logic [board_pkg::ACT_N-1:0]     i_act,      // Indexed by act_e
  output logic [board_pkg::SEG_W-1:0]     o_hex0,
  output logic [board_pkg::SEG_W-1:0]     o_hex1,
  output logic [board_pkg::SEG_W-1:0]     o_hex2,
  output logic [board_pkg::SEG_W-1:0]     o_hex3,
  output logic [board_pkg::LEDG_W-1:0]    o_ledg,
  output logic [board_pkg::LEDR_W-1:0]    o_ledr
);

  typedef logic [$clog2(STRETCH+1)-1:0] cnt_t;

  logic [board_pkg::SEG_W-1:0] hex0_q;
  logic [board_pkg::SEG_W-1:0] hex1_q;
  logic [board_pkg::SEG_W-1:0] hex2_q;
  cnt_t                        cnt_q [board_pkg::ACT_N];   // Stretch counters

  //////////////////////////////
  // Digits
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (i_reset) begin
      hex0_q <= board_pkg::SEG_BLANK;
      hex1_q <= board_pkg::SEG_BLANK;
      hex2_q <= board_pkg::SEG_BLANK;
    end else begin
      hex0_q <= board_pkg::SEG_HEX[i_track[3:0]];                     // Low nibble
      hex1_q <= board_pkg::SEG_HEX[i_track[board_pkg::TRACK_W-1:4]];  // High nibble
      hex2_q <= board_pkg::SEG_HEX[cfg.sys_status];
    end
  end

  assign o_hex0 = hex0_q;
  assign o_hex1 = hex1_q;
  assign o_hex2 = hex2_q;
  assign o_hex3 = board_pkg::SEG_BLANK;             // Unused digit

  //////////////////////////////
  // Activity LEDs
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < board_pkg::ACT_N; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < board_pkg::ACT_N; i++) begin
        if (i_act[i]) begin
          cnt_q[i] <= cnt_t'(STRETCH);              // Reload on every strobe
        end else if (cnt_q[i] != '0) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  always_comb begin
    o_ledg = '0;                                    // Upper LEDs dark
    o_ledg[board_pkg::ACT_FLOPPY_WR] = (cnt_q[board_pkg::ACT_FLOPPY_WR] != '0);
    o_ledg[board_pkg::ACT_FLOPPY_RD] = (cnt_q[board_pkg::ACT_FLOPPY_RD] != '0);
    o_ledg[board_pkg::ACT_HD_WR]     = (cnt_q[board_pkg::ACT_HD_WR] != '0);
    o_ledg[board_pkg::ACT_HD_RD]     = (cnt_q[board_pkg::ACT_HD_RD] != '0);
  end

  // Red LEDs follow CTRL bit order
  assign o_ledr = {
    {(board_pkg::LEDR_W - 5){1'b0}},
    cfg.cache_en,
    cfg.scan15k,
    cfg.mix,
    cfg.exchan,
    cfg.uart_ctrl
  };

  // Lit LED always backed by a running counter
  for (genvar g = 0; g < board_pkg::ACT_N; g++) begin : g_led_chk
    a_lit_cnt : assert property (@(posedge clk) disable iff (i_reset)
      o_ledg[g] |-> cnt_q[g] != '0);
  end

endmodule

/* tb/tb_board_glue.sv */
// Board glue testbench: random AXI4-Lite, audio, UART and indicator
// stimulus against a reference model, per-test report, cycle limit
module tb_board_glue;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int T1_LEN = 40;       // Reset and first reads
  localparam int T2_LEN = 700;      // CTRL writes and readback
  localparam int T3_LEN = 180;      // Audio, four settings
  localparam int T4_LEN = 200;      // UART routing
  localparam int T5_LEN = 210;      // Indicators
  localparam int LIMIT  = 2 * (T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN);

  logic clk = 1'b0;
  logic reset;
  logic [csr_pkg::ADDR_W-1:0] awaddr, araddr;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [csr_pkg::DATA_W-1:0] wdata, rdata;
  logic [3:0] wstrb;
  logic [1:0] bresp, rresp;
  logic [board_pkg::STATUS_W-1:0] sys_status;
  logic [board_pkg::TRACK_W-1:0] track;
  logic [board_pkg::ACT_N-1:0] act;
  logic sample_valid, out_valid;
  board_pkg::sample_t left, right, out_left, out_right;
  logic ctrl_txd, ctrl_rxd, core_txd, core_rxd, uart_rxd, uart_txd;
  logic scan15k, cache_en;
  logic [board_pkg::SEG_W-1:0] hex0, hex1, hex2, hex3;
  logic [board_pkg::LEDG_W-1:0] ledg;
  logic [board_pkg::LEDR_W-1:0] ledr;

  logic [csr_pkg::CTRL_W-1:0] ctrl_m = '0;   // Model of CTRL
  int cnt_m [board_pkg::ACT_N];              // Model of stretch counters
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycles = 0;

  board_glue_top dut0 (
    .clk (clk), .i_reset (reset),
    .i_awaddr (awaddr), .i_awvalid (awvalid), .o_awready (awready),
    .i_wdata (wdata), .i_wstrb (wstrb), .i_wvalid (wvalid), .o_wready (wready),
    .o_bresp (bresp), .o_bvalid (bvalid), .i_bready (bready),
    .i_araddr (araddr), .i_arvalid (arvalid), .o_arready (arready),
    .o_rdata (rdata), .o_rresp (rresp), .o_rvalid (rvalid), .i_rready (rready),
    .i_sys_status (sys_status), .i_track (track), .i_act (act),
    .i_sample_valid (sample_valid), .i_left (left), .i_right (right),
    .o_sample_valid (out_valid), .o_left (out_left), .o_right (out_right),
    .i_ctrl_txd (ctrl_txd), .o_ctrl_rxd (ctrl_rxd),
    .i_core_txd (core_txd), .o_core_rxd (core_rxd),
    .i_uart_rxd (uart_rxd), .o_uart_txd (uart_txd),
    .o_scan15k (scan15k), .o_cache_en (cache_en),
    .o_hex0 (hex0), .o_hex1 (hex1), .o_hex2 (hex2), .o_hex3 (hex3),
    .o_ledg (ledg), .o_ledr (ledr)
  );

  always #10 clk = ~clk;                     // 20 ns period

  // Watchdog on total run length
  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Active-low hex digit from the usual segment sets
  function automatic logic [6:0] seg_of(input logic [3:0] nib);
    logic [6:0] lit;                         // Active-high gfedcba
    case (nib)
      4'h0: lit = 7'h3f;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5b;
      4'h3: lit = 7'h4f;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6d;
      4'h6: lit = 7'h7d;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7f;
      4'h9: lit = 7'h6f;
      4'ha: lit = 7'h77;
      4'hb: lit = 7'h7c;
      4'hc: lit = 7'h39;
      4'hd: lit = 7'h5e;
      4'he: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  // One output channel, own channel weighted three to one
  function automatic board_pkg::sample_t mix_sample(input int own, input int other,
                                                    input logic mix_on);
    int sum;
    sum = 3 * own + other;
    if (mix_on) return board_pkg::sample_t'(sum >>> 2);
    return board_pkg::sample_t'(own);
  endfunction

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [1:0] exp_resp;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do @(negedge clk); while (!awready);     // Accept on the coming edge
    check_value(wready, 1'b1, "wready with awready");
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    exp_resp = csr_pkg::RESP_SLVERR;         // Read-only and holes
    if (addr == csr_pkg::REG_CTRL) begin
      exp_resp = csr_pkg::RESP_OKAY;
      if (strb[0]) ctrl_m = data[csr_pkg::CTRL_W-1:0];
    end
    repeat ($urandom_range(3, 0)) @(negedge clk);   // Slow bready
    check_value(bvalid, 1'b1, "bvalid");
    check_value(bresp, exp_resp, "bresp");
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read_check(input logic [3:0] addr);
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    check_value(arready, 1'b1, "arready idle");
    do @(negedge clk); while (!rvalid);
    arvalid  = 1'b0;
    exp_data = '0;
    exp_resp = csr_pkg::RESP_OKAY;
    case (addr)
      csr_pkg::REG_CTRL:   exp_data = 32'(ctrl_m);
      csr_pkg::REG_STATUS: exp_data = 32'(sys_status);
      csr_pkg::REG_ID:     exp_data = csr_pkg::BOARD_ID;
      default:             exp_resp = csr_pkg::RESP_SLVERR;
    endcase
    repeat ($urandom_range(3, 0)) @(negedge clk);   // Slow rready
    check_value(rvalid, 1'b1, "rvalid");
    check_value(arready, 1'b0, "arready with pending rvalid");
    check_value(rdata, exp_data, "rdata");
    check_value(rresp, exp_resp, "rresp");
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic check_ctrl_outputs();
    check_value(ledr, 32'(ctrl_m), "ledr mirror");
    check_value(scan15k, ctrl_m[csr_pkg::CTRL_SCAN15K], "scan15k");
    check_value(cache_en, ctrl_m[csr_pkg::CTRL_CACHE_EN], "cache_en");
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors > errs_before) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errs_before);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int errs;
    int a;
    int b;
    logic prev_valid;
    board_pkg::sample_t prev_l, prev_r;
    logic [board_pkg::TRACK_W-1:0] prev_track;
    logic [board_pkg::STATUS_W-1:0] prev_status;
    void'($urandom(32'h5373962b));
    reset = 1'b1;
    {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
    {araddr, arvalid, rready} = '0;
    sys_status = 4'($urandom);
    {track, act, sample_valid, left, right} = '0;
    {ctrl_txd, core_txd, uart_rxd} = 3'b111;     // Idle lines
    foreach (cnt_m[i]) cnt_m[i] = 0;

    // 1: reset state and first reads
    errs = errors;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value({hex3, hex2, hex1, hex0}, {4{7'h7f}}, "digits blank in reset");
    check_value(ledg, '0, "ledg after reset");
    check_value({bvalid, rvalid, awready, wready, out_valid}, '0, "handshakes idle");
    check_ctrl_outputs();
    reset = 1'b0;
    axi_read_check(csr_pkg::REG_CTRL);
    axi_read_check(csr_pkg::REG_STATUS);
    axi_read_check(csr_pkg::REG_ID);
    finish_test("test 1 reset and identity", errs);

    // 2: CTRL writes, read-only and unmapped writes
    errs = errors;
    axi_write(csr_pkg::REG_STATUS, $urandom, 4'hf);
    axi_write(csr_pkg::REG_ID, $urandom, 4'hf);
    axi_read_check(csr_pkg::REG_CTRL);
    repeat (40) begin
      axi_write($urandom_range(1, 0) ? 4'h0 : 4'($urandom), $urandom, 4'($urandom));
      axi_read_check(csr_pkg::REG_CTRL);
      check_ctrl_outputs();
      axi_read_check(4'($urandom));          // Any address, holes included
    end
    finish_test("test 2 register access", errs);

    // 3: sample path under each exchange and mix setting
    errs = errors;
    for (int s = 0; s < 4; s++) begin
      axi_write(csr_pkg::REG_CTRL, 32'({2'($urandom), s[1], s[0], 1'($urandom)}),
                4'h1);                                  // Mix s[1], exchange s[0]
      prev_valid = 1'b0;
      for (int n = 0; n <= 32; n++) begin
        @(negedge clk);
        check_value(out_valid, prev_valid, "sample valid");
        if (prev_valid) begin
          check_value(out_left, prev_l, "left sample");
          check_value(out_right, prev_r, "right sample");
        end
        sample_valid = (n < 32) ? 1'($urandom) : 1'b0;
        left  = board_pkg::sample_t'($urandom);
        right = board_pkg::sample_t'($urandom);
        a = ctrl_m[csr_pkg::CTRL_EXCHAN] ? right : left;    // Swap first
        b = ctrl_m[csr_pkg::CTRL_EXCHAN] ? left  : right;
        prev_l = mix_sample(a, b, ctrl_m[csr_pkg::CTRL_MIX]);
        prev_r = mix_sample(b, a, ctrl_m[csr_pkg::CTRL_MIX]);
        prev_valid = sample_valid;
      end
    end
    finish_test("test 3 audio exchange and mix", errs);

    // 4: UART routing
    errs = errors;
    repeat (12) begin
      axi_write(csr_pkg::REG_CTRL, $urandom, 4'hf);
      repeat (4) begin
        @(negedge clk);
        {ctrl_txd, core_txd, uart_rxd} = 3'($urandom);
        @(negedge clk);
        if (ctrl_m[csr_pkg::CTRL_UART_CTRL]) begin
          check_value({uart_txd, ctrl_rxd, core_rxd}, {ctrl_txd, uart_rxd, 1'b1}, "uart ctrl");
        end else begin
          check_value({uart_txd, ctrl_rxd, core_rxd}, {core_txd, 1'b1, uart_rxd}, "uart core");
        end
      end
    end
    finish_test("test 4 uart routing", errs);

    // 5: digits and stretched activity LEDs
    errs = errors;
    prev_track  = track;
    prev_status = sys_status;
    repeat (200) begin
      @(negedge clk);
      check_value(hex0, seg_of(prev_track[3:0]), "hex0");
      check_value(hex1, seg_of(prev_track[7:4]), "hex1");
      check_value(hex2, seg_of(prev_status), "hex2");
      check_value(hex3, 7'h7f, "hex3");
      check_value(ledg[board_pkg::LEDG_W-1:board_pkg::ACT_N], '0, "upper ledg");
      for (int i = 0; i < board_pkg::ACT_N; i++) begin
        check_value(ledg[i], cnt_m[i] != 0, "activity led");
      end
      track      = 8'($urandom);
      sys_status = 4'($urandom);
      prev_track  = track;
      prev_status = sys_status;
      for (int i = 0; i < board_pkg::ACT_N; i++) begin
        act[i] = ($urandom_range(3, 0) == 0);          // Sparse strobes
        if (act[i]) cnt_m[i] = board_pkg::STRETCH_LEN;
        else if (cnt_m[i] != 0) cnt_m[i]--;
      end
    end
    act = '0;
    finish_test("test 5 indicators", errs);

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* verilog.f */
design/board_pkg.sv
design/csr_pkg.sv
design/board_cfg_if.sv
design/board_csr.sv
design/audio_mix.sv
design/status_display.sv
design/board_glue_top.sv
tb/tb_board_glue.sv
